//--- Makefile
# Verilator build and run for the DRAM FIFO testbench

VERILATOR ?= verilator
TOP       ?= tb_dram_fifo
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

//--- files.f
hw/dram_fifo_pkg.sv
hw/word_buffer.sv
hw/burst_scheduler.sv
hw/fifo_occupancy.sv
hw/axi_burst_master.sv
hw/dram_fifo_top.sv
verification/axi_mem_model.sv
verification/tb_dram_fifo.sv

//--- hw/axi_burst_master.sv
`timescale 1ns/1ps

module axi_burst_master (
   input  logic                       dram_clk,
   input  logic                       input_timeout_reset,
   input  logic                       i_clear,
   // Write commands and data
   input  dram_fifo_pkg::burst_cmd_t  i_wr_cmd,
   input  logic                       i_wr_cmd_valid,
   output logic                       o_wr_cmd_ready,
   input  dram_fifo_pkg::word_t       i_wr_data,
   input  logic                       i_wr_data_valid,
   output logic                       o_wr_data_ready,
   // Read commands and data
   input  dram_fifo_pkg::burst_cmd_t  i_rd_cmd,
   input  logic                       i_rd_cmd_valid,
   output logic                       o_rd_cmd_ready,
   output dram_fifo_pkg::word_t       o_rd_data,
   output logic                       o_rd_data_valid,
   input  logic                       i_rd_data_ready,
   // AXI write
   output dram_fifo_pkg::axi_addr_t   o_aw,
   output logic                       o_awvalid,
   input  logic                       i_awready,
   output dram_fifo_pkg::word_t       o_wdata,
   output logic                       o_wlast,
   output logic                       o_wvalid,
   input  logic                       i_wready,
   input  logic                       i_bvalid,
   output logic                       o_bready,
   // AXI read
   output dram_fifo_pkg::axi_addr_t   o_ar,
   output logic                       o_arvalid,
   input  logic                       i_arready,
   input  dram_fifo_pkg::word_t       i_rdata,
   input  logic                       i_rlast,
   input  logic                       i_rvalid,
   output logic                       o_rready
);

   logic                              w_active;  // W beats still owed
   logic                              r_active;
   logic [dram_fifo_pkg::COUNT_W-1:0] w_beat;
   logic                              wr_accept;
   logic                              rd_accept;
   logic                              w_fire;
   logic                              r_fire;

   assign wr_accept = i_wr_cmd_valid && o_wr_cmd_ready;
   assign rd_accept = i_rd_cmd_valid && o_rd_cmd_ready;

   ////////////////////
   // Write engine
   assign o_wdata         = i_wr_data;
   assign o_wvalid        = w_active && i_wr_data_valid;
   assign o_wlast         = w_active && (w_beat == o_aw.len);   // Beat count+1
   assign o_wr_data_ready = w_active && i_wready;
   assign o_bready        = 1'b1;
   assign w_fire          = o_wvalid && i_wready;

   always_ff @(posedge dram_clk) begin
      if (input_timeout_reset || i_clear) begin
         o_wr_cmd_ready <= 1'b1;
         o_awvalid      <= 1'b0;
         w_active       <= 1'b0;
         w_beat         <= '0;
      end else begin
         if (o_awvalid && i_awready)
            o_awvalid <= 1'b0;
         if (w_fire) begin
            w_beat <= w_beat + 1'b1;
            if (o_wlast)
               w_active <= 1'b0;
         end
         if (i_bvalid)
            o_wr_cmd_ready <= 1'b1;   // Response closes the burst
         if (wr_accept) begin
            o_wr_cmd_ready <= 1'b0;
            o_awvalid      <= 1'b1;
            w_active       <= 1'b1;
            w_beat         <= '0;
         end
      end
   end

   ////////////////////
   // Read engine
   assign o_rd_data       = i_rdata;
   assign o_rd_data_valid = r_active && i_rvalid;
   assign o_rready        = r_active && i_rd_data_ready;   // Only with buffer room
   assign r_fire          = i_rvalid && o_rready;

   always_ff @(posedge dram_clk) begin
      if (input_timeout_reset || i_clear) begin
         o_rd_cmd_ready <= 1'b1;
         o_arvalid      <= 1'b0;
         r_active       <= 1'b0;
      end else begin
         if (o_arvalid && i_arready)
            o_arvalid <= 1'b0;
         if (r_fire && i_rlast) begin
            r_active       <= 1'b0;
            o_rd_cmd_ready <= 1'b1;
         end
         if (rd_accept) begin
            o_rd_cmd_ready <= 1'b0;
            o_arvalid      <= 1'b1;
            r_active       <= 1'b1;
         end
      end
   end

   // Address payloads, captured with the command
   always_ff @(posedge dram_clk) begin
      if (wr_accept)
         o_aw <= '{addr: 32'(i_wr_cmd.addr), len: i_wr_cmd.count};
      if (rd_accept)
         o_ar <= '{addr: 32'(i_rd_cmd.addr), len: i_rd_cmd.count};
   end

endmodule

//--- hw/burst_scheduler.sv
`timescale 1ns/1ps

module burst_scheduler (
   input  logic                              dram_clk,
   input  logic                              input_timeout_reset,
   input  logic                              i_clear,
   input  dram_fifo_pkg::dram_fifo_cfg_t     i_cfg,
   input  logic [dram_fifo_pkg::LEVEL_W-1:0] i_src_level,
   input  logic [dram_fifo_pkg::LEVEL_W-1:0] i_dst_room,
   output dram_fifo_pkg::burst_cmd_t         o_cmd,
   output logic                              o_cmd_valid,
   input  logic                              i_cmd_ready,
   output logic                              o_burst_done
);

   dram_fifo_pkg::burst_state_e         state;
   logic [dram_fifo_pkg::ADDR_W-1:0]    cur_addr;
   logic [dram_fifo_pkg::COUNT_W-1:0]   cmd_count;
   logic [dram_fifo_pkg::TIMEOUT_W-1:0] tmo_count;
   logic                                tmo_hit;
   logic                                src_big;
   logic                                start;
   logic [dram_fifo_pkg::LEVEL_W-1:0]   burst_m1;
   logic [dram_fifo_pkg::LEVEL_W-1:0]   page_rem;
   logic [dram_fifo_pkg::LEVEL_W-1:0]   full_lim;
   logic [dram_fifo_pkg::LEVEL_W-1:0]   src_m1;
   logic [dram_fifo_pkg::ADDR_W-1:0]    step_bytes;
   logic [dram_fifo_pkg::ADDR_W-1:0]    next_addr;

   assign o_cmd = '{addr: cur_addr, count: cmd_count};

   ////////////////////
   // Trigger and sizing
   assign burst_m1 = dram_fifo_pkg::LEVEL_W'(dram_fifo_pkg::BURST_WORDS - 1);
   assign src_big  = (i_src_level > burst_m1);
   assign start    = (state == dram_fifo_pkg::ST_IDLE) && (i_dst_room > burst_m1)
                     && (src_big || (tmo_hit && i_src_level != '0));

   // Words left in the 4 KB page, minus one
   assign page_rem = dram_fifo_pkg::LEVEL_W'(dram_fifo_pkg::PAGE_WORDS - 1)
                     - dram_fifo_pkg::LEVEL_W'(cur_addr[11:3]);
   assign full_lim = (page_rem < burst_m1) ? page_rem : burst_m1;
   assign src_m1   = i_src_level - 1'b1;

   // Advance inside the window, masked bits stay on the base
   assign step_bytes = (dram_fifo_pkg::ADDR_W'(cmd_count) + 1'b1)
                       * dram_fifo_pkg::ADDR_W'(dram_fifo_pkg::WORD_BYTES);
   assign next_addr  = ((cur_addr + step_bytes) & ~i_cfg.addr_mask)
                       | (i_cfg.base_addr & i_cfg.addr_mask);

   ////////////////////
   // Idle timeout
   always_ff @(posedge dram_clk) begin
      if (input_timeout_reset || i_clear || start) begin
         tmo_count <= '0;
         tmo_hit   <= 1'b0;
      end else if (tmo_count == i_cfg.timeout) begin
         tmo_hit <= 1'b1;                           // Sticks until a burst starts
      end else if (state == dram_fifo_pkg::ST_IDLE && i_src_level != '0) begin
         tmo_count <= tmo_count + 1'b1;
      end
   end

   ////////////////////
   // Burst FSM
   always_ff @(posedge dram_clk) begin
      if (input_timeout_reset || i_clear) begin
         state        <= dram_fifo_pkg::ST_IDLE;
         cur_addr     <= i_cfg.base_addr & i_cfg.addr_mask;
         cmd_count    <= '0;
         o_cmd_valid  <= 1'b0;
         o_burst_done <= 1'b0;
      end else begin
         o_burst_done <= 1'b0;
         case (state)
            dram_fifo_pkg::ST_IDLE: begin
               if (start)
                  state <= src_big ? dram_fifo_pkg::ST_FULL_BURST
                                   : dram_fifo_pkg::ST_TIMEOUT_BURST;
            end
            dram_fifo_pkg::ST_FULL_BURST: begin
               cmd_count   <= dram_fifo_pkg::COUNT_W'(full_lim);   // Lesser of 256 and page
               o_cmd_valid <= 1'b1;
               state       <= dram_fifo_pkg::ST_WAIT_ACCEPT;
            end
            dram_fifo_pkg::ST_TIMEOUT_BURST: begin
               // Source may have grown meanwhile, so cap at the full limit too
               cmd_count   <= dram_fifo_pkg::COUNT_W'((src_m1 < full_lim) ? src_m1 : full_lim);
               o_cmd_valid <= 1'b1;
               state       <= dram_fifo_pkg::ST_WAIT_ACCEPT;
            end
            dram_fifo_pkg::ST_WAIT_ACCEPT: begin
               if (i_cmd_ready) begin                      // Accepted this cycle
                  o_cmd_valid <= 1'b0;
                  state       <= dram_fifo_pkg::ST_WAIT_BUSY;
               end
            end
            dram_fifo_pkg::ST_WAIT_BUSY: begin
               if (!i_cmd_ready)
                  state <= dram_fifo_pkg::ST_WAIT_DONE;
            end
            dram_fifo_pkg::ST_WAIT_DONE: begin
               if (i_cmd_ready) begin                      // Burst committed
                  cur_addr     <= next_addr;
                  o_burst_done <= 1'b1;
                  state        <= dram_fifo_pkg::ST_SETTLE;
               end
            end
            dram_fifo_pkg::ST_SETTLE: state <= dram_fifo_pkg::ST_IDLE;  // Let levels update
            default:                  state <= dram_fifo_pkg::ST_IDLE;
         endcase
      end
   end

   // AXI4 rule, no burst crosses a 4 KB page
   a_page: assert property (@(posedge dram_clk)
      disable iff (input_timeout_reset || i_clear)
      o_cmd_valid |-> (dram_fifo_pkg::LEVEL_W'(o_cmd.addr[11:3])
                       + dram_fifo_pkg::LEVEL_W'(o_cmd.count))
                      < dram_fifo_pkg::LEVEL_W'(dram_fifo_pkg::PAGE_WORDS));

   // Command held steady until the master takes it
   a_cmd_hold: assert property (@(posedge dram_clk)
      disable iff (input_timeout_reset || i_clear)
      o_cmd_valid && !i_cmd_ready |=> o_cmd_valid && $stable(o_cmd));

endmodule

//--- hw/dram_fifo_pkg.sv
package dram_fifo_pkg;

   ////////////////////
   // Widths
   localparam int DATA_W         = 64;  // Stream and DRAM word
   localparam int ADDR_W         = 30;  // Byte address inside FIFO window
   localparam int COUNT_W        = 8;   // Burst length minus one
   localparam int LEVEL_W        = 16;  // Buffer and DRAM level counts
   localparam int TIMEOUT_W      = 12;
   localparam int BUF_DEPTH_LOG2 = 10;  // 1024-word on-chip buffers

   ////////////////////
   // Thresholds and geometry
   localparam int BURST_WORDS    = 256; // Full burst, also the trigger level
   localparam int PAGE_WORDS     = 512; // 4 KB page in 64-bit words
   localparam int DRAM_HEADROOM  = 64;  // Slack for controller reordering
   localparam int WORD_BYTES     = 8;

   typedef logic [DATA_W-1:0] word_t;

   // Static configuration, replaces the settings registers
   typedef struct packed {
      logic [ADDR_W-1:0]    base_addr;
      logic [ADDR_W-1:0]    addr_mask;  // Ones pick base bits, zeros are FIFO space
      logic [TIMEOUT_W-1:0] timeout;    // Idle cycles before a short burst
   } dram_fifo_cfg_t;

   typedef struct packed {
      logic [ADDR_W-1:0]  addr;
      logic [COUNT_W-1:0] count;        // Words minus one
   } burst_cmd_t;

   // AW / AR channel payload
   typedef struct packed {
      logic [31:0]        addr;
      logic [COUNT_W-1:0] len;
   } axi_addr_t;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_FULL_BURST,    // Size a 256-word burst
      ST_TIMEOUT_BURST, // Size a partial burst
      ST_WAIT_ACCEPT,
      ST_WAIT_BUSY,     // Ready must drop first
      ST_WAIT_DONE,     // Ready back high means burst complete
      ST_SETTLE
   } burst_state_e;

endpackage

//--- hw/dram_fifo_top.sv
`timescale 1ns/1ps

module dram_fifo_top (
   input  logic                          dram_clk,
   input  logic                          input_timeout_reset,
   input  logic                          i_clear,
   input  dram_fifo_pkg::dram_fifo_cfg_t i_cfg,
   // Stream in
   input  dram_fifo_pkg::word_t          i_tdata,
   input  logic                          i_tvalid,
   output logic                          o_tready,
   // Stream out
   output dram_fifo_pkg::word_t          o_tdata,
   output logic                          o_tvalid,
   input  logic                          i_tready,
   // AXI write
   output dram_fifo_pkg::axi_addr_t      o_aw,
   output logic                          o_awvalid,
   input  logic                          i_awready,
   output dram_fifo_pkg::word_t          o_wdata,
   output logic                          o_wlast,
   output logic                          o_wvalid,
   input  logic                          i_wready,
   input  logic                          i_bvalid,
   output logic                          o_bready,
   // AXI read
   output dram_fifo_pkg::axi_addr_t      o_ar,
   output logic                          o_arvalid,
   input  logic                          i_arready,
   input  dram_fifo_pkg::word_t          i_rdata,
   input  logic                          i_rlast,
   input  logic                          i_rvalid,
   output logic                          o_rready
);

   dram_fifo_pkg::word_t              wr_data, rd_data;
   logic                              wr_data_valid, wr_data_ready;
   logic                              rd_data_valid, rd_data_ready;
   logic [dram_fifo_pkg::LEVEL_W-1:0] in_level, out_space;
   logic [dram_fifo_pkg::LEVEL_W-1:0] dram_occupied, dram_space;
   dram_fifo_pkg::burst_cmd_t         wr_cmd, rd_cmd;
   logic                              wr_cmd_valid, wr_cmd_ready, wr_done;
   logic                              rd_cmd_valid, rd_cmd_ready, rd_done;

   ////////////////////
   // On-chip buffers
   word_buffer u_in_buf (
      .dram_clk, .input_timeout_reset, .i_clear,
      .i_data(i_tdata), .i_valid(i_tvalid), .o_ready(o_tready),
      .o_data(wr_data), .o_valid(wr_data_valid), .i_ready(wr_data_ready),
      .o_space(), .o_occupied(in_level));

   word_buffer u_out_buf (
      .dram_clk, .input_timeout_reset, .i_clear,
      .i_data(rd_data), .i_valid(rd_data_valid), .o_ready(rd_data_ready),
      .o_data(o_tdata), .o_valid(o_tvalid), .i_ready(i_tready),
      .o_space(out_space), .o_occupied());

   ////////////////////
   // Schedulers, input buffer to DRAM and DRAM to output buffer
   burst_scheduler u_wr_sched (
      .dram_clk, .input_timeout_reset, .i_clear, .i_cfg,
      .i_src_level(in_level), .i_dst_room(dram_space),
      .o_cmd(wr_cmd), .o_cmd_valid(wr_cmd_valid), .i_cmd_ready(wr_cmd_ready),
      .o_burst_done(wr_done));

   burst_scheduler u_rd_sched (
      .dram_clk, .input_timeout_reset, .i_clear, .i_cfg,
      .i_src_level(dram_occupied), .i_dst_room(out_space),
      .o_cmd(rd_cmd), .o_cmd_valid(rd_cmd_valid), .i_cmd_ready(rd_cmd_ready),
      .o_burst_done(rd_done));

   fifo_occupancy u_occupancy (
      .dram_clk, .input_timeout_reset, .i_clear, .i_cfg,
      .i_wr_done(wr_done), .i_wr_cmd(wr_cmd), .i_rd_done(rd_done), .i_rd_cmd(rd_cmd),
      .o_occupied(dram_occupied), .o_space(dram_space));

   axi_burst_master u_master (
      .dram_clk, .input_timeout_reset, .i_clear,
      .i_wr_cmd(wr_cmd), .i_wr_cmd_valid(wr_cmd_valid), .o_wr_cmd_ready(wr_cmd_ready),
      .i_wr_data(wr_data), .i_wr_data_valid(wr_data_valid), .o_wr_data_ready(wr_data_ready),
      .i_rd_cmd(rd_cmd), .i_rd_cmd_valid(rd_cmd_valid), .o_rd_cmd_ready(rd_cmd_ready),
      .o_rd_data(rd_data), .o_rd_data_valid(rd_data_valid), .i_rd_data_ready(rd_data_ready),
      .o_aw, .o_awvalid, .i_awready, .o_wdata, .o_wlast, .o_wvalid, .i_wready,
      .i_bvalid, .o_bready,
      .o_ar, .o_arvalid, .i_arready, .i_rdata, .i_rlast, .i_rvalid, .o_rready);

endmodule

//--- hw/fifo_occupancy.sv
`timescale 1ns/1ps

module fifo_occupancy (
   input  logic                              dram_clk,
   input  logic                              input_timeout_reset,
   input  logic                              i_clear,
   input  dram_fifo_pkg::dram_fifo_cfg_t     i_cfg,
   input  logic                              i_wr_done,
   input  dram_fifo_pkg::burst_cmd_t         i_wr_cmd,
   input  logic                              i_rd_done,
   input  dram_fifo_pkg::burst_cmd_t         i_rd_cmd,
   output logic [dram_fifo_pkg::LEVEL_W-1:0] o_occupied,
   output logic [dram_fifo_pkg::LEVEL_W-1:0] o_space
);

   logic [dram_fifo_pkg::LEVEL_W-1:0] wr_words;
   logic [dram_fifo_pkg::LEVEL_W-1:0] rd_words;
   logic [dram_fifo_pkg::LEVEL_W-1:0] init_space;

   // Word counts of the bursts that just completed
   assign wr_words = i_wr_done ? dram_fifo_pkg::LEVEL_W'(i_wr_cmd.count) + 1'b1 : '0;
   assign rd_words = i_rd_done ? dram_fifo_pkg::LEVEL_W'(i_rd_cmd.count) + 1'b1 : '0;

   // Window words less headroom, on a 64-word grid
   assign init_space = (dram_fifo_pkg::LEVEL_W'(~i_cfg.addr_mask[dram_fifo_pkg::ADDR_W-1:3])
                        + 1'b1 - dram_fifo_pkg::LEVEL_W'(dram_fifo_pkg::DRAM_HEADROOM))
                       & ~dram_fifo_pkg::LEVEL_W'(dram_fifo_pkg::DRAM_HEADROOM - 1);

   always_ff @(posedge dram_clk) begin
      if (input_timeout_reset || i_clear) begin
         o_occupied <= '0;
         o_space    <= init_space;
      end else begin
         o_occupied <= o_occupied + wr_words - rd_words;
         o_space    <= o_space - wr_words + rd_words;   // Mirror of occupied
      end
   end

   // Reads never outrun writes and writes never overfill the window
   a_conserve: assert property (@(posedge dram_clk)
      disable iff (input_timeout_reset || i_clear)
      o_occupied <= init_space);

endmodule

//--- hw/word_buffer.sv
`timescale 1ns/1ps

module word_buffer (
   input  logic                              dram_clk,
   input  logic                              input_timeout_reset,
   input  logic                              i_clear,
   input  dram_fifo_pkg::word_t              i_data,
   input  logic                              i_valid,
   output logic                              o_ready,
   output dram_fifo_pkg::word_t              o_data,
   output logic                              o_valid,
   input  logic                              i_ready,
   output logic [dram_fifo_pkg::LEVEL_W-1:0] o_space,
   output logic [dram_fifo_pkg::LEVEL_W-1:0] o_occupied
);

   dram_fifo_pkg::word_t                     mem [2**dram_fifo_pkg::BUF_DEPTH_LOG2];
   logic [dram_fifo_pkg::BUF_DEPTH_LOG2-1:0] wr_ptr;
   logic [dram_fifo_pkg::BUF_DEPTH_LOG2-1:0] rd_ptr;
   logic [dram_fifo_pkg::LEVEL_W-1:0]        count;
   logic [dram_fifo_pkg::LEVEL_W-1:0]        depth;
   logic                                     wr_en;
   logic                                     rd_en;

   assign depth      = dram_fifo_pkg::LEVEL_W'(2**dram_fifo_pkg::BUF_DEPTH_LOG2);
   assign o_ready    = (count != depth);
   assign o_valid    = (count != '0);
   assign o_data     = mem[rd_ptr];       // Head word, visible cycle after write
   assign o_space    = depth - count;
   assign o_occupied = count;
   assign wr_en      = i_valid && o_ready;
   assign rd_en      = o_valid && i_ready;

   always_ff @(posedge dram_clk) begin
      if (wr_en)
         mem[wr_ptr] <= i_data;
   end

   always_ff @(posedge dram_clk) begin
      if (input_timeout_reset || i_clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;    // Pointers wrap on their own
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count + dram_fifo_pkg::LEVEL_W'(wr_en) - dram_fifo_pkg::LEVEL_W'(rd_en);
      end
   end

   // Level never runs past the RAM depth, so no write lands on a full buffer
   a_no_overwrite: assert property (@(posedge dram_clk)
      disable iff (input_timeout_reset || i_clear)
      count <= depth);

endmodule

//--- verification/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model (
   input  logic                     dram_clk,
   input  logic                     input_timeout_reset,
   input  logic [3:0]               i_stall,   // AW, W, R, AR hold-off bits
   input  dram_fifo_pkg::axi_addr_t i_aw,
   input  logic                     i_awvalid,
   output logic                     o_awready,
   input  dram_fifo_pkg::word_t     i_wdata,
   input  logic                     i_wlast,
   input  logic                     i_wvalid,
   output logic                     o_wready,
   output logic                     o_bvalid,
   input  logic                     i_bready,
   input  dram_fifo_pkg::axi_addr_t i_ar,
   input  logic                     i_arvalid,
   output logic                     o_arready,
   output dram_fifo_pkg::word_t     o_rdata,
   output logic                     o_rlast,
   output logic                     o_rvalid,
   input  logic                     i_rready
);

   dram_fifo_pkg::word_t              mem [1024];   // One 8 KB window
   logic [9:0]                        w_idx;
   logic [9:0]                        r_idx;
   logic                              aw_got;       // Address taken, W beats open
   logic                              r_busy;
   logic [dram_fifo_pkg::COUNT_W-1:0] r_left;       // Beats left minus one
   logic                              w_fire;
   logic                              r_fire;

   assign o_awready = !aw_got && !o_bvalid && !i_stall[0];
   assign o_wready  = aw_got && !i_stall[1];
   assign o_arready = !r_busy && !i_stall[3];
   assign o_rdata   = mem[r_idx];
   assign o_rlast   = o_rvalid && (r_left == '0);
   assign w_fire    = i_wvalid && o_wready;
   assign r_fire    = o_rvalid && i_rready;

   always_ff @(posedge dram_clk) begin
      if (w_fire)
         mem[w_idx] <= i_wdata;
   end

   ////////////////////
   // Write side, one burst at a time
   always_ff @(posedge dram_clk) begin
      if (input_timeout_reset) begin
         aw_got   <= 1'b0;
         o_bvalid <= 1'b0;
         w_idx    <= '0;
      end else begin
         if (o_bvalid && i_bready)
            o_bvalid <= 1'b0;
         if (i_awvalid && o_awready) begin
            w_idx  <= i_aw.addr[12:3];   // Word index inside the window
            aw_got <= 1'b1;
         end
         if (w_fire) begin
            w_idx <= w_idx + 1'b1;
            if (i_wlast) begin
               aw_got   <= 1'b0;
               o_bvalid <= 1'b1;           // Single-cycle response
            end
         end
      end
   end

   ////////////////////
   // Read side, rvalid holds until taken
   always_ff @(posedge dram_clk) begin
      if (input_timeout_reset) begin
         r_busy   <= 1'b0;
         o_rvalid <= 1'b0;
         r_idx    <= '0;
         r_left   <= '0;
      end else if (i_arvalid && o_arready) begin
         r_idx  <= i_ar.addr[12:3];
         r_left <= i_ar.len;
         r_busy <= 1'b1;
      end else if (r_fire) begin
         o_rvalid <= 1'b0;                 // Gap after each beat
         r_idx    <= r_idx + 1'b1;
         r_left   <= r_left - 1'b1;
         if (r_left == '0)
            r_busy <= 1'b0;
      end else if (r_busy && !o_rvalid && !i_stall[2]) begin
         o_rvalid <= 1'b1;
      end
   end

endmodule

//--- verification/tb_dram_fifo.sv
`timescale 1ns/1ps

module tb_dram_fifo;

   localparam int          CLK_PERIOD   = 40;
   localparam int          STREAM_WORDS = 3000;
   localparam int          DRAIN_LIMIT  = 20000;
   localparam logic [31:0] SEED         = 32'd27724;
   localparam logic [31:0] BASE_ADDR    = 32'h0010_0000;
   localparam logic [31:0] ADDR_MASK    = 32'h3FFF_E000;   // 8 KB window
   // Cycle estimates per test: reset, timeout, stream, hold, clear
   localparam int          TEST_CYCLES  = 20 + 400 + 9000 + 14000 + 3000;
   localparam int          WATCHDOG     = 4 * TEST_CYCLES;

   logic                          dram_clk;
   logic                          input_timeout_reset;
   logic                          i_clear;
   dram_fifo_pkg::dram_fifo_cfg_t cfg;
   dram_fifo_pkg::word_t          i_tdata, o_tdata, wdata, rdata;
   logic                          i_tvalid, o_tready, o_tvalid;
   logic                          i_tready = 1'b0;
   dram_fifo_pkg::axi_addr_t      aw, ar;
   logic                          awvalid, awready, wlast, wvalid, wready, bvalid, bready;
   logic                          arvalid, arready, rlast, rvalid, rready;
   logic [3:0]                    stall = 4'b0000;
   logic                          sink_en;                 // Output consumer enabled
   logic [31:0]                   data_rng;
   logic [31:0]                   stall_rng = SEED;
   logic [31:0]                   exp_aw_addr, exp_ar_addr;
   dram_fifo_pkg::word_t          exp_q [$];               // Words owed at the output
   int                            err_count = 0;
   int                            check_count = 0;

   dram_fifo_top DUT (
      .dram_clk, .input_timeout_reset, .i_clear, .i_cfg(cfg),
      .i_tdata, .i_tvalid, .o_tready, .o_tdata, .o_tvalid, .i_tready,
      .o_aw(aw), .o_awvalid(awvalid), .i_awready(awready), .o_wdata(wdata),
      .o_wlast(wlast), .o_wvalid(wvalid), .i_wready(wready), .i_bvalid(bvalid),
      .o_bready(bready), .o_ar(ar), .o_arvalid(arvalid), .i_arready(arready),
      .i_rdata(rdata), .i_rlast(rlast), .i_rvalid(rvalid), .o_rready(rready));

   axi_mem_model u_mem (
      .dram_clk, .input_timeout_reset(input_timeout_reset || i_clear), .i_stall(stall),
      .i_aw(aw), .i_awvalid(awvalid), .o_awready(awready), .i_wdata(wdata),
      .i_wlast(wlast), .i_wvalid(wvalid), .o_wready(wready), .o_bvalid(bvalid),
      .i_bready(bready), .i_ar(ar), .i_arvalid(arvalid), .o_arready(arready),
      .o_rdata(rdata), .o_rlast(rlast), .o_rvalid(rvalid), .i_rready(rready));

   initial begin
      dram_clk = 1'b0;
      forever #(CLK_PERIOD / 2) dram_clk = ~dram_clk;
   end

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Next burst start, wraps inside the window and keeps the base bits
   function automatic logic [31:0] advance_addr(input logic [31:0] addr, input logic [7:0] len);
      logic [31:0] step;
      step = (32'(len) + 32'd1) * 32'd8;
      return ((addr + step) & ~ADDR_MASK) | (BASE_ADDR & ADDR_MASK);
   endfunction

   task automatic make_word(output dram_fifo_pkg::word_t w);
      logic [31:0] hi;
      data_rng = lcg_step(data_rng);
      hi       = data_rng;
      data_rng = lcg_step(data_rng);
      w        = {hi, data_rng};
   endtask

   ////////////////////
   // Compare tasks
   task automatic compare_bit(input string name, input logic exp, input logic got);
      check_count++;
      if (got !== exp) begin
         err_count++;
         $display("Fail at %0t: %s expected %b got %b", $time, name, exp, got);
      end
   endtask

   task automatic compare_word(input string name, input dram_fifo_pkg::word_t exp,
                               input dram_fifo_pkg::word_t got);
      check_count++;
      if (got !== exp) begin
         err_count++;
         $display("Fail at %0t: %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   task automatic compare_axi_addr(input string name, input logic [31:0] exp_addr,
                                   input dram_fifo_pkg::axi_addr_t got);
      logic [12:0] end_byte;
      check_count++;
      if (got.addr !== exp_addr) begin
         err_count++;
         $display("Fail at %0t: %s.addr expected %h got %h", $time, name, exp_addr, got.addr);
      end
      end_byte = 13'(got.addr[11:0]) + (13'(got.len) + 13'd1) * 13'd8;
      if (end_byte > 13'd4096) begin
         err_count++;
         $display("Error at %0t: %s burst of %0d words at %h runs past a 4 KB page",
                  $time, name, got.len + 1, got.addr);
      end
   endtask

   ////////////////////
   // Stall bits and output ready, both from the LCG
   always @(negedge dram_clk) begin
      stall_rng = lcg_step(stall_rng);
      stall[0]  = (stall_rng[31:30] == 2'b00);   // One in four cycles held off
      stall[1]  = (stall_rng[29:28] == 2'b00);
      stall[2]  = (stall_rng[27:26] == 2'b00);
      stall[3]  = (stall_rng[25:24] == 2'b00);
      i_tready  = sink_en && (stall_rng[23:22] != 2'b00);
   end

   // Scoreboard and address checks, sampled just ahead of each rising edge
   initial begin
      forever begin
         @(negedge dram_clk);
         #(CLK_PERIOD / 2 - 1);
         if (input_timeout_reset || i_clear) begin
            exp_q.delete();                       // Stored words are discarded
            exp_aw_addr = BASE_ADDR;
            exp_ar_addr = BASE_ADDR;
         end else begin
            if (i_tvalid && o_tready)
               exp_q.push_back(i_tdata);
            if (o_tvalid && i_tready) begin
               if (exp_q.size() == 0) begin
                  err_count++;
                  $display("Error at %0t: o_tdata word %h came out with none expected",
                           $time, o_tdata);
               end else begin
                  compare_word("o_tdata", exp_q.pop_front(), o_tdata);
               end
            end
            if (awvalid && awready) begin
               compare_axi_addr("o_aw", exp_aw_addr, aw);
               exp_aw_addr = advance_addr(exp_aw_addr, aw.len);
            end
            if (arvalid && arready) begin
               compare_axi_addr("o_ar", exp_ar_addr, ar);
               exp_ar_addr = advance_addr(exp_ar_addr, ar.len);
            end
         end
      end
   end

   ////////////////////
   // Stream helpers, called on a falling edge
   task automatic send_word(input dram_fifo_pkg::word_t w);
      i_tdata  = w;
      i_tvalid = 1'b1;
      while (!o_tready)
         @(negedge dram_clk);
      @(negedge dram_clk);                        // Taken on the edge just passed
   endtask

   task automatic send_random_words(input int n);
      dram_fifo_pkg::word_t w;
      for (int i = 0; i < n; i++) begin
         make_word(w);
         send_word(w);
      end
      i_tvalid = 1'b0;
   endtask

   task automatic wait_drain(input int limit);
      int cycles;
      cycles = 0;
      while ((exp_q.size() != 0) && (cycles < limit)) begin
         @(negedge dram_clk);
         cycles++;
      end
      if (exp_q.size() != 0) begin
         err_count++;
         $display("Error at %0t: %0d words never came out within %0d cycles",
                  $time, exp_q.size(), limit);
      end
      repeat (200) @(negedge dram_clk);           // Any extra word shows up here
   endtask

   ////////////////////
   // Directed tests
   task automatic check_reset_state();
      compare_bit("o_tvalid", 1'b0, o_tvalid);
      compare_bit("o_awvalid", 1'b0, awvalid);
      compare_bit("o_arvalid", 1'b0, arvalid);
      compare_bit("o_wvalid", 1'b0, wvalid);
      compare_bit("o_tready", 1'b1, o_tready);
   endtask

   task automatic flush_by_timeout();
      sink_en = 1'b1;
      send_random_words(5);
      repeat (30) @(negedge dram_clk);
      compare_bit("o_awvalid", 1'b0, awvalid);     // Well short of the 64-cycle timeout
      wait_drain(1000);
   endtask

   task automatic stream_random();
      sink_en = 1'b1;
      send_random_words(STREAM_WORDS);             // Wraps the 1024-word window
      wait_drain(DRAIN_LIMIT);
   endtask

   task automatic hold_output();
      dram_fifo_pkg::word_t w;
      int                   sent;
      int                   stuck;
      sent    = 0;
      stuck   = 0;
      sink_en = 1'b0;
      make_word(w);
      i_tvalid = 1'b1;
      while ((stuck < 1000) && (sent < 6000)) begin
         i_tdata = w;
         if (o_tready) begin
            sent++;
            stuck = 0;
            make_word(w);
         end else begin
            stuck++;
         end
         @(negedge dram_clk);
      end
      i_tvalid = 1'b0;
      compare_bit("o_tready", 1'b0, o_tready);     // All three stages full
      sink_en = 1'b1;
      wait_drain(DRAIN_LIMIT);
   endtask

   task automatic clear_midstream();
      sink_en = 1'b0;
      send_random_words(300);
      i_clear = 1'b1;
      repeat (3) @(negedge dram_clk);
      i_clear = 1'b0;
      compare_bit("o_tvalid", 1'b0, o_tvalid);
      sink_en = 1'b1;
      send_random_words(40);
      wait_drain(2000);
   endtask

   initial begin
      input_timeout_reset = 1'b1;
      i_clear             = 1'b0;
      i_tvalid            = 1'b0;
      i_tdata             = '0;
      sink_en             = 1'b0;
      data_rng            = SEED;
      cfg = '{base_addr: BASE_ADDR[29:0], addr_mask: ADDR_MASK[29:0], timeout: 12'd64};
      repeat (10) @(negedge dram_clk);
      input_timeout_reset = 1'b0;
      check_reset_state();
      flush_by_timeout();
      stream_random();
      hold_output();
      clear_midstream();
      $display("Checks: %0d, errors: %0d", check_count, err_count);
      if (err_count == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

   initial begin
      repeat (WATCHDOG) @(posedge dram_clk);
      $display("Watchdog expired after %0d cycles with tests still running", WATCHDOG);
      $display("Test failed");
      $finish;
   end

endmodule
